// ==== udp_rxbuf_top.f ====
+incdir+logic
logic/udp_rxbuf_pkg.sv
logic/rxbuf_ram.sv
logic/rxbuf_arbiter.sv
logic/udp_rx_writer.sv
logic/rx_size_monitor.sv
logic/udp_rxbuf_top.sv
tests/udp_rxbuf_asserts.sv
tests/tb_udp_rxbuf.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass message.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f udp_rxbuf_top.f --top-module tb_udp_rxbuf > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_udp_rxbuf > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log

grep -q "^>>> PASS$" sim.log && echo "simulation log shows success" \
    || { echo "simulation log shows no success"; exit 1; }

// ==== tests/tb_udp_rxbuf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rxbuf_defs.svh"

module tb_udp_rxbuf;

    import udp_rxbuf_pkg::*;

    localparam int TIMEOUT_CYCLES = 500;
    localparam int CAPACITY = (1 << `RXBUF_AWIDTH) - `RXBUF_PAYLOAD_BASE;

    logic                       clk;
    logic                       rst_n;
    rx_beat_t                   rx_beat;
    logic                       rx_ready;
    logic [`RX_SIZE_WIDTH-1:0]  drop_count;
    logic [`RX_SIZE_WIDTH-1:0]  last_rx_size;
    logic [`RXBUF_DWIDTH-1:0]   rx_digest;
    logic                       rx_done;
    led_t                       leds;

    integer                     seed;
    int                         errors;
    int                         checks;
    int                         tests;
    int                         test_errors;
    int                         exp_size;
    int                         exp_drops;
    logic [`RXBUF_DWIDTH-1:0]   exp_digest;
    int                         k;
    int                         n;
    int                         extra;
    int                         prev_drops;
    int                         boundary_words [0:3] = '{2, 3, 5, 6};
    logic [2:0]                 boundary_leds [0:3] = '{3'b100, 3'b010, 3'b010, 3'b001};

    udp_rxbuf_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .rx_beat      (rx_beat),
        .rx_ready     (rx_ready),
        .drop_count   (drop_count),
        .last_rx_size (last_rx_size),
        .rx_digest    (rx_digest),
        .rx_done      (rx_done),
        .leds         (leds)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // led bits are {red, green, blue}.
    function automatic logic [2:0] expected_leds(input int size);
        logic [2:0] led;
        led = 3'b000;
        if (size >= 1 && size <= `LED_RED_MAX) begin
            led = 3'b100;
        end else if (size > `LED_RED_MAX && size <= `LED_GREEN_MAX) begin
            led = 3'b010;
        end else if (size > `LED_GREEN_MAX) begin
            led = 3'b001;
        end
        return led;
    endfunction

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_ready(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rx_ready && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!rx_ready) begin
            $display("%s: rx_ready stayed low for %0d cycles", name, TIMEOUT_CYCLES);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rx_done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!rx_done) begin
            $display("%s: rx_done never pulsed within %0d cycles", name, TIMEOUT_CYCLES);
            errors++;
            test_errors++;
        end
    endtask

    // extra beats follow the last word while the writer is busy, so they are dropped.
    task automatic send_packet(input string name, input int words, input int extra);
        int stored;
        int i;
        int j;
        logic [31:0] data;
        stored = 0;
        exp_digest = '0;
        wait_ready(name);
        for (i = 0; i < words; i++) begin
            data = $random(seed);
            if (stored < CAPACITY) begin
                exp_digest = exp_digest ^ data;
                stored++;
            end else begin
                exp_drops++;
            end
            @(posedge clk);
            rx_beat <= {1'b1, (i == words - 1), data};
        end
        for (j = 0; j < extra; j++) begin
            data = $random(seed);
            @(posedge clk);
            rx_beat <= {1'b1, data[0], data};
            exp_drops++;
        end
        @(posedge clk);
        rx_beat <= '0;
        exp_size = 4 * stored;
    endtask

    task automatic check_packet(input string name);
        wait_done(name);
        compare({name, " size"}, exp_size, last_rx_size);
        compare({name, " digest"}, exp_digest, rx_digest);
        compare({name, " leds"}, expected_leds(exp_size), leds);
        compare({name, " drop_count"}, exp_drops, drop_count);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        seed = 90;
        errors = 0;
        checks = 0;
        tests = 0;
        test_errors = 0;
        exp_drops = 0;
        rst_n = 1'b0;
        rx_beat = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        compare("reset rx_ready", 1, rx_ready);
        compare("reset drop_count", 0, drop_count);
        compare("reset last_rx_size", 0, last_rx_size);
        compare("reset rx_digest", 0, rx_digest);
        compare("reset leds", 0, leds);
        end_test("reset");

        for (k = 0; k < 8; k++) begin
            n = 1 + ($unsigned($random(seed)) % 8);
            send_packet("random_single", n, 0);
            check_packet("random_single");
        end
        end_test("random_single");

        for (k = 0; k < 4; k++) begin
            send_packet("boundary", boundary_words[k], 0);
            check_packet("boundary");
            compare("boundary led band", boundary_leds[k], leds);
        end
        end_test("boundary");

        for (k = 0; k < 3; k++) begin
            n = 1 + ($unsigned($random(seed)) % 8);
            extra = 1 + ($unsigned($random(seed)) % 4);
            send_packet("late_drop", n, extra);
            check_packet("late_drop");
            n = 1 + ($unsigned($random(seed)) % 8);
            send_packet("after_drop", n, 0);
            check_packet("after_drop");
        end
        end_test("late_drop");

        prev_drops = exp_drops;
        send_packet("overflow", 70, 0);
        check_packet("overflow");
        compare("overflow size", 248, last_rx_size);
        compare("overflow drop_count", prev_drops + 8, drop_count);
        end_test("overflow");

        for (k = 0; k < 20; k++) begin
            n = 1 + ($unsigned($random(seed)) % CAPACITY);
            send_packet("back_to_back", n, 0);
            check_packet("back_to_back");
        end
        end_test("back_to_back");

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/udp_rxbuf_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_rxbuf_asserts (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                net_grant,
    input  logic                cpu_grant,
    input  logic                net_rel,
    input  logic                cpu_rel,
    input  logic                rx_ready,
    input  logic                rx_done,
    input  udp_rxbuf_pkg::led_t leds
);

    // ownership only moves on a release pulse from the side that held the buffer.
    grant_on_release: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(cpu_grant) |-> $past(net_grant ? net_rel : cpu_rel))
        else $error("buffer ownership moved without a release from its owner");

    // the network side may not take words while the CPU side reads.
    no_ready_on_cpu: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_ready && cpu_grant))
        else $error("rx_ready is high while the CPU side owns the buffer");

    // the buffer is handed back with rx_done, so rx_ready is up one cycle later.
    done_with_release: assert property (@(posedge clk) disable iff (!rst_n)
        rx_done |=> (rx_ready && $past(cpu_rel)))
        else $error("rx_done pulsed without cpu_rel or rx_ready stayed low after it");

    single_led: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(leds))
        else $error("more than one LED is lit");

endmodule

bind udp_rxbuf_top udp_rxbuf_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .net_grant (net_grant),
    .cpu_grant (cpu_grant),
    .net_rel   (net_rel),
    .cpu_rel   (cpu_rel),
    .rx_ready  (rx_ready),
    .rx_done   (rx_done),
    .leds      (leds)
);

`default_nettype wire

// ==== logic/udp_rxbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rxbuf_defs.svh"

module udp_rxbuf_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  udp_rxbuf_pkg::rx_beat_t   rx_beat,
    output logic                      rx_ready,
    output logic [`RX_SIZE_WIDTH-1:0] drop_count,
    output logic [`RX_SIZE_WIDTH-1:0] last_rx_size,
    output logic [`RXBUF_DWIDTH-1:0]  rx_digest,
    output logic                      rx_done,
    output udp_rxbuf_pkg::led_t       leds
);

    import udp_rxbuf_pkg::*;

    rxbuf_req_t                net_req;
    rxbuf_req_t                cpu_req;
    logic                      net_rel;
    logic                      cpu_rel;
    logic                      net_grant;
    logic                      cpu_grant;
    logic [`RXBUF_DWIDTH-1:0]  rd_data;

    udp_rx_writer u_writer (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx_beat    (rx_beat),
        .net_grant  (net_grant),
        .rx_ready   (rx_ready),
        .drop_count (drop_count),
        .net_req    (net_req),
        .net_rel    (net_rel)
    );

    rx_size_monitor u_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_grant    (cpu_grant),
        .rd_data      (rd_data),
        .cpu_req      (cpu_req),
        .cpu_rel      (cpu_rel),
        .rx_done      (rx_done),
        .last_rx_size (last_rx_size),
        .rx_digest    (rx_digest),
        .leds         (leds)
    );

    rxbuf_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .net_req   (net_req),
        .cpu_req   (cpu_req),
        .net_rel   (net_rel),
        .cpu_rel   (cpu_rel),
        .net_grant (net_grant),
        .cpu_grant (cpu_grant),
        .rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/rx_size_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rxbuf_defs.svh"

module rx_size_monitor (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cpu_grant,
    input  logic [`RXBUF_DWIDTH-1:0]  rd_data,
    output udp_rxbuf_pkg::rxbuf_req_t cpu_req,
    output logic                      cpu_rel,
    output logic                      rx_done,
    output logic [`RX_SIZE_WIDTH-1:0] last_rx_size,
    output logic [`RXBUF_DWIDTH-1:0]  rx_digest,
    output udp_rxbuf_pkg::led_t       leds
);

    import udp_rxbuf_pkg::*;

    localparam int AW = `RXBUF_AWIDTH;

    monitor_state_e             state;
    logic                       first;
    logic                       pend;
    logic [AW-1:0]              iss_cnt;
    logic [`RX_SIZE_WIDTH-1:0]  size_q;
    logic [`RX_SIZE_WIDTH-1:0]  size_now;
    logic [AW-1:0]              words_now;
    logic [`RXBUF_DWIDTH-1:0]   digest_acc;
    logic                       issue;
    logic                       done;
    led_t                       led_next;

    // in the first data cycle the size word sits on rd_data.
    assign size_now  = first ? rd_data[`RXBUF_DWIDTH-1 -: `RX_SIZE_WIDTH] : size_q;
    assign words_now = size_now[AW+1:2];
    assign issue     = (state == MON_DATA) && (iss_cnt < words_now);
    assign done      = (state == MON_DATA) && !first && !pend && !issue;

    always_comb begin
        cpu_req = '0;
        if (state == MON_SIZE) begin
            cpu_req.ce   = 1'b1;
            cpu_req.addr = AW'(`RXBUF_SIZE_ADDR);
        end else if (issue) begin
            cpu_req.ce   = 1'b1;
            cpu_req.addr = AW'(`RXBUF_PAYLOAD_BASE) + iss_cnt;
        end
    end

    always_comb begin
        led_next.red   = (size_q >= 1) && (size_q <= `LED_RED_MAX);
        led_next.green = (size_q > `LED_RED_MAX) && (size_q <= `LED_GREEN_MAX);
        led_next.blue  = (size_q > `LED_GREEN_MAX);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= MON_WAIT;
            first        <= 1'b0;
            pend         <= 1'b0;
            iss_cnt      <= '0;
            cpu_rel      <= 1'b0;
            rx_done      <= 1'b0;
            last_rx_size <= '0;
            rx_digest    <= '0;
            leds         <= '0;
        end else begin
            cpu_rel <= 1'b0;
            rx_done <= 1'b0;
            case (state)
                MON_WAIT: begin
                    if (cpu_grant) begin
                        state <= MON_SIZE;
                    end
                end
                MON_SIZE: begin
                    first   <= 1'b1;
                    pend    <= 1'b0;
                    iss_cnt <= '0;
                    state   <= MON_DATA;
                end
                MON_DATA: begin
                    first <= 1'b0;
                    pend  <= issue;  // one payload read stays in flight.
                    if (issue) begin
                        iss_cnt <= iss_cnt + 1'b1;
                    end
                    if (done) begin
                        last_rx_size <= size_q;
                        rx_digest    <= digest_acc;
                        leds         <= led_next;
                        rx_done      <= 1'b1;
                        cpu_rel      <= 1'b1;
                        state        <= MON_RELEASE;
                    end
                end
                MON_RELEASE: begin
                    state <= MON_WAIT;  // grant has moved back by now.
                end
                default: begin
                    state <= MON_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MON_SIZE) begin
            digest_acc <= '0;
        end else if ((state == MON_DATA) && pend) begin
            digest_acc <= digest_acc ^ rd_data;
        end
        if ((state == MON_DATA) && first) begin
            size_q <= size_now;
        end
    end

endmodule

`default_nettype wire

// ==== logic/udp_rx_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rxbuf_defs.svh"

module udp_rx_writer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  udp_rxbuf_pkg::rx_beat_t   rx_beat,
    input  logic                      net_grant,
    output logic                      rx_ready,
    output logic [`RX_SIZE_WIDTH-1:0] drop_count,
    output udp_rxbuf_pkg::rxbuf_req_t net_req,
    output logic                      net_rel
);

    import udp_rxbuf_pkg::*;

    // one extra bit lets the pointer reach the end of the buffer without wrapping.
    localparam int                PTR_W    = `RXBUF_AWIDTH + 1;
    localparam logic [PTR_W-1:0]  PTR_BASE = PTR_W'(`RXBUF_PAYLOAD_BASE);
    localparam logic [PTR_W-1:0]  PTR_END  = PTR_W'(1 << `RXBUF_AWIDTH);

    writer_state_e              state;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           stored;
    logic [`RX_SIZE_WIDTH-1:0]  byte_cnt;
    logic                       accept;
    logic                       full;
    logic                       drop;

    // net_rel is still high while the grant has not yet moved over.
    assign rx_ready = net_grant && (state == WR_COLLECT) && !net_rel;
    assign accept   = rx_beat.valid && rx_ready;
    assign full     = (wr_ptr == PTR_END);
    assign drop     = rx_beat.valid && (!rx_ready || full);
    assign stored   = wr_ptr - PTR_BASE;
    assign byte_cnt = {{(`RX_SIZE_WIDTH - PTR_W - 2){1'b0}}, stored, 2'b00};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= WR_COLLECT;
            wr_ptr     <= PTR_BASE;
            drop_count <= '0;
            net_req    <= '0;
            net_rel    <= 1'b0;
        end else begin
            net_req.ce <= 1'b0;
            net_req.we <= 1'b0;
            net_rel    <= 1'b0;

            if (drop) begin
                drop_count <= drop_count + 1'b1;
            end

            case (state)
                WR_COLLECT: begin
                    if (accept) begin
                        if (!full) begin
                            net_req.ce    <= 1'b1;
                            net_req.we    <= 1'b1;
                            net_req.addr  <= wr_ptr[`RXBUF_AWIDTH-1:0];
                            net_req.wdata <= rx_beat.data;
                            wr_ptr        <= wr_ptr + 1'b1;
                        end
                        if (rx_beat.last) begin
                            state <= WR_SIZE;  // last still closes an overflowing packet.
                        end
                    end
                end
                WR_SIZE: begin
                    net_req.ce    <= 1'b1;
                    net_req.we    <= 1'b1;
                    net_req.addr  <= `RXBUF_AWIDTH'(`RXBUF_SIZE_ADDR);
                    net_req.wdata <= {byte_cnt, {(`RXBUF_DWIDTH - `RX_SIZE_WIDTH){1'b0}}};
                    state         <= WR_RELEASE;
                end
                WR_RELEASE: begin
                    net_rel <= 1'b1;
                    wr_ptr  <= PTR_BASE;
                    state   <= WR_COLLECT;
                end
                default: begin
                    state <= WR_COLLECT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/rxbuf_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rxbuf_defs.svh"

module rxbuf_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  udp_rxbuf_pkg::rxbuf_req_t net_req,
    input  udp_rxbuf_pkg::rxbuf_req_t cpu_req,
    input  logic                      net_rel,
    input  logic                      cpu_rel,
    output logic                      net_grant,
    output logic                      cpu_grant,
    output logic [`RXBUF_DWIDTH-1:0]  rd_data
);

    import udp_rxbuf_pkg::*;

    rxbuf_owner_e owner;
    rxbuf_req_t   ram_req;

    // the buffer only changes hands on a release from its current owner.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            owner <= OWNER_NET;
        end else begin
            case (owner)
                OWNER_NET: begin
                    if (net_rel) begin
                        owner <= OWNER_CPU;
                    end
                end
                OWNER_CPU: begin
                    if (cpu_rel) begin
                        owner <= OWNER_NET;
                    end
                end
                default: begin
                    owner <= OWNER_NET;
                end
            endcase
        end
    end

    assign net_grant = (owner == OWNER_NET);
    assign cpu_grant = (owner == OWNER_CPU);

    always_comb begin
        if (owner == OWNER_NET) begin
            ram_req = net_req;
        end else begin
            ram_req = cpu_req;  // requests from the other side never reach the RAM.
        end
    end

    rxbuf_ram u_ram (
        .clk     (clk),
        .req     (ram_req),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== logic/rxbuf_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "udp_rxbuf_defs.svh"

module rxbuf_ram (
    input  logic                      clk,
    input  udp_rxbuf_pkg::rxbuf_req_t req,
    output logic [`RXBUF_DWIDTH-1:0]  rd_data
);

    localparam int DEPTH = 1 << `RXBUF_AWIDTH;

    logic [`RXBUF_DWIDTH-1:0] mem [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (req.ce) begin
            if (req.we) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rd_data <= mem[req.addr];  // data shows up one cycle after the read.
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/udp_rxbuf_pkg.sv ====
`default_nettype none

`include "udp_rxbuf_defs.svh"

package udp_rxbuf_pkg;

    // one word from the network side, valid is a single-cycle strobe.
    typedef struct packed {
        logic                      valid;
        logic                      last;
        logic [`RXBUF_DWIDTH-1:0]  data;
    } rx_beat_t;

    // one access to the shared buffer RAM.
    typedef struct packed {
        logic                      ce;
        logic                      we;
        logic [`RXBUF_AWIDTH-1:0]  addr;
        logic [`RXBUF_DWIDTH-1:0]  wdata;
    } rxbuf_req_t;

    typedef enum logic {
        OWNER_NET,
        OWNER_CPU
    } rxbuf_owner_e;

    typedef enum logic [1:0] {
        WR_COLLECT,
        WR_SIZE,
        WR_RELEASE
    } writer_state_e;

    typedef enum logic [1:0] {
        MON_WAIT,
        MON_SIZE,
        MON_DATA,
        MON_RELEASE
    } monitor_state_e;

    typedef struct packed {
        logic red;
        logic green;
        logic blue;
    } led_t;

endpackage

`default_nettype wire

// ==== logic/udp_rxbuf_defs.svh ====
`ifndef UDP_RXBUF_DEFS_SVH
`define UDP_RXBUF_DEFS_SVH

// buffer geometry, 64 words of 32 bits.
`define RXBUF_AWIDTH 6
`define RXBUF_DWIDTH 32

// word 1 holds the byte count in its upper half, payload starts at word 2.
`define RXBUF_SIZE_ADDR 1
`define RXBUF_PAYLOAD_BASE 2

// upper byte counts for the red and green LED bands.
`define LED_RED_MAX 10
`define LED_GREEN_MAX 20

// byte count and drop counter width.
`define RX_SIZE_WIDTH 16

`endif
